//--- hw/rv_core_pkg.sv
// Shared widths, vector types, opcode and ALU enums, exception codes
// and the forwarding record of the RV32I integer core
`default_nettype none

package rv_core_pkg;

   localparam int XLEN      = 32;
   localparam int RF_AWIDTH = 5;

   typedef logic [XLEN-1:0]      xlen_t;     // Data word
   typedef logic [RF_AWIDTH-1:0] rf_addr_t;  // Register address
   typedef logic [31:0]          instr_t;    // Instruction word
   typedef logic [3:0]           exc_code_t; // Exception cause

   // Major opcode, instr[6:2]
   typedef enum logic [4:0] {
      OPCODE_IMM   = 5'b00100,
      OPCODE_AUIPC = 5'b00101,
      OPCODE_ARITH = 5'b01100,
      OPCODE_LUI   = 5'b01101
   } rv_opcode_e;

   typedef enum logic [3:0] {
      ALU_OP_NONE,
      ALU_OP_ADD,
      ALU_OP_SUB,
      ALU_OP_SLL,
      ALU_OP_SLT,
      ALU_OP_SLTU,
      ALU_OP_XOR,
      ALU_OP_SRL,
      ALU_OP_SRA,
      ALU_OP_OR,
      ALU_OP_AND,
      ALU_OP_COPY_OPR2  // LUI passes the immediate
   } alu_op_e;

   typedef enum logic {
      OPR1_REG,
      OPR1_PC
   } opr1_sel_e;

   typedef enum logic {
      OPR2_REG,
      OPR2_IMM
   } opr2_sel_e;

   localparam exc_code_t EXC_NONE        = 4'd0;
   localparam exc_code_t EXC_INSTR_FAULT = 4'd1;  // Fetch access fault
   localparam exc_code_t EXC_ILLEGAL     = 4'd2;  // Illegal instruction

   // Result still in flight, fed back to decode
   typedef struct packed {
      logic     valid;
      rf_addr_t rd_addr;
      xlen_t    rd_data;
   } fwd_t;

endpackage : rv_core_pkg

`default_nettype wire

//--- hw/id2exe_if.sv
// Decode to execute pipeline bundle, registered strobe with no handshake
`default_nettype none

interface id2exe_if #(
   parameter int XLEN = rv_core_pkg::XLEN
);
   import rv_core_pkg::*;

   logic            valid;
   logic [XLEN-1:0] pc;
   logic [XLEN-1:0] rs1_data;   // Forwarded operands
   logic [XLEN-1:0] rs2_data;
   logic [XLEN-1:0] imm;
   rf_addr_t        rd_addr;
   alu_op_e         alu_op;
   opr1_sel_e       opr1_sel;
   opr2_sel_e       opr2_sel;
   logic            rd_wr_req;
   logic            exc_req;
   exc_code_t       exc_code;

   modport decode (
      output valid, pc, rs1_data, rs2_data, imm, rd_addr,
             alu_op, opr1_sel, opr2_sel, rd_wr_req, exc_req, exc_code
   );

   modport execute (
      input  valid, pc, rs1_data, rs2_data, imm, rd_addr,
             alu_op, opr1_sel, opr2_sel, rd_wr_req, exc_req, exc_code
   );

endinterface : id2exe_if

`default_nettype wire

//--- hw/reg_file.sv
// Integer register file, two read ports and one write port with write-first bypass
`default_nettype none

module reg_file #(
   parameter int XLEN = rv_core_pkg::XLEN
) (
   input  wire logic                clk,
   input  wire logic                arst_n_i,
   input  wire rv_core_pkg::rf_addr_t rs1_addr_i,
   input  wire rv_core_pkg::rf_addr_t rs2_addr_i,
   output logic [XLEN-1:0]          rs1_data_o,
   output logic [XLEN-1:0]          rs2_data_o,
   input  wire logic                wr_en_i,
   input  wire rv_core_pkg::rf_addr_t wr_addr_i,
   input  wire logic [XLEN-1:0]     wr_data_i
);
   import rv_core_pkg::*;

   logic [XLEN-1:0] regs_q [1:2**RF_AWIDTH-1];  // x0 is not stored

   function automatic logic [XLEN-1:0] read_reg(input rf_addr_t addr);
      logic [XLEN-1:0] data;
      if (addr == '0) begin
         data = '0;
      end else if (wr_en_i && (wr_addr_i == addr)) begin
         data = wr_data_i;  // Same-cycle write wins
      end else begin
         data = regs_q[addr];
      end
      return data;
   endfunction

   always_ff @(posedge clk or negedge arst_n_i) begin
      if (!arst_n_i) begin
         for (int i = 1; i < 2**RF_AWIDTH; i++) begin
            regs_q[i] <= '0;
         end
      end else if (wr_en_i && (wr_addr_i != '0)) begin
         regs_q[wr_addr_i] <= wr_data_i;
      end
   end

   always_comb begin
      rs1_data_o = read_reg(rs1_addr_i);
      rs2_data_o = read_reg(rs2_addr_i);
   end

endmodule : reg_file

`default_nettype wire

//--- hw/instr_decode.sv
// Instruction decoder, immediate generation, operand forwarding
// and the decode to execute pipeline register
`default_nettype none

module instr_decode #(
   parameter int XLEN = rv_core_pkg::XLEN
) (
   input  wire logic                  clk,
   input  wire logic                  arst_n_i,
   input  wire logic                  instr_valid_i,
   input  wire rv_core_pkg::instr_t   instr_i,
   input  wire logic [XLEN-1:0]       pc_i,
   input  wire logic                  fetch_fault_i,
   output rv_core_pkg::rf_addr_t      rs1_addr_o,
   output rv_core_pkg::rf_addr_t      rs2_addr_o,
   input  wire logic [XLEN-1:0]       rs1_data_i,
   input  wire logic [XLEN-1:0]       rs2_data_i,
   input  wire rv_core_pkg::fwd_t     exe_fwd_i,
   input  wire rv_core_pkg::fwd_t     wb_fwd_i,
   id2exe_if.decode                   id2exe
);
   import rv_core_pkg::*;

   rv_opcode_e      opcode;
   logic [6:0]      funct7;
   logic [2:0]      funct3;
   logic [4:0]      shamt;
   logic            illegal;
   alu_op_e         alu_op;
   opr1_sel_e       opr1_sel;
   opr2_sel_e       opr2_sel;
   logic            rd_wr_req;
   logic            exc_req;
   exc_code_t       exc_code;
   logic [XLEN-1:0] imm;

   // Youngest in-flight result first, then the register file
   function automatic logic [XLEN-1:0] fwd_operand(input rf_addr_t addr,
                                                   input logic [XLEN-1:0] rf_data);
      logic [XLEN-1:0] data;
      data = rf_data;
      if (addr != '0) begin
         if (exe_fwd_i.valid && (exe_fwd_i.rd_addr == addr)) begin
            data = exe_fwd_i.rd_data;
         end else if (wb_fwd_i.valid && (wb_fwd_i.rd_addr == addr)) begin
            data = wb_fwd_i.rd_data;
         end
      end
      return data;
   endfunction

   assign opcode     = rv_opcode_e'(instr_i[6:2]);
   assign funct7     = instr_i[31:25];
   assign funct3     = instr_i[14:12];
   assign shamt      = instr_i[24:20];
   assign rs1_addr_o = instr_i[19:15];
   assign rs2_addr_o = instr_i[24:20];

   always_comb begin
      alu_op    = ALU_OP_NONE;
      opr1_sel  = OPR1_REG;
      opr2_sel  = OPR2_REG;
      rd_wr_req = 1'b0;
      exc_req   = 1'b0;
      exc_code  = EXC_NONE;
      imm       = XLEN'({{20{instr_i[31]}}, instr_i[31:20]});  // I-type default
      illegal   = 1'b0;

      if (fetch_fault_i) begin  // Fault takes priority over decode
         exc_req  = 1'b1;
         exc_code = EXC_INSTR_FAULT;
      end else if (instr_i[1:0] != 2'b11) begin
         illegal = 1'b1;  // Compressed encodings not supported
      end else begin
         case (opcode)
            OPCODE_ARITH: begin
               rd_wr_req = 1'b1;
               if (funct7 == 7'h00) begin
                  case (funct3)
                     3'b000:  alu_op = ALU_OP_ADD;
                     3'b001:  alu_op = ALU_OP_SLL;
                     3'b010:  alu_op = ALU_OP_SLT;
                     3'b011:  alu_op = ALU_OP_SLTU;
                     3'b100:  alu_op = ALU_OP_XOR;
                     3'b101:  alu_op = ALU_OP_SRL;
                     3'b110:  alu_op = ALU_OP_OR;
                     default: alu_op = ALU_OP_AND;
                  endcase
               end else if ((funct7 == 7'h20) && (funct3 == 3'b000)) begin
                  alu_op = ALU_OP_SUB;
               end else if ((funct7 == 7'h20) && (funct3 == 3'b101)) begin
                  alu_op = ALU_OP_SRA;
               end else begin
                  illegal = 1'b1;  // Includes the M extension
               end
            end
            OPCODE_IMM: begin
               opr2_sel  = OPR2_IMM;
               rd_wr_req = 1'b1;
               case (funct3)
                  3'b000: alu_op = ALU_OP_ADD;
                  3'b010: alu_op = ALU_OP_SLT;
                  3'b011: alu_op = ALU_OP_SLTU;
                  3'b100: alu_op = ALU_OP_XOR;
                  3'b110: alu_op = ALU_OP_OR;
                  3'b111: alu_op = ALU_OP_AND;
                  3'b001: begin
                     imm     = XLEN'(shamt);  // Zero-extended shift amount
                     alu_op  = ALU_OP_SLL;
                     illegal = (funct7 != 7'h00);
                  end
                  default: begin  // SRLI or SRAI
                     imm = XLEN'(shamt);
                     if (funct7 == 7'h00) begin
                        alu_op = ALU_OP_SRL;
                     end else if (funct7 == 7'h20) begin
                        alu_op = ALU_OP_SRA;
                     end else begin
                        illegal = 1'b1;
                     end
                  end
               endcase
            end
            OPCODE_LUI: begin
               opr2_sel  = OPR2_IMM;
               alu_op    = ALU_OP_COPY_OPR2;
               rd_wr_req = 1'b1;
               imm       = XLEN'({instr_i[31:12], 12'b0});
            end
            OPCODE_AUIPC: begin
               opr1_sel  = OPR1_PC;
               opr2_sel  = OPR2_IMM;
               alu_op    = ALU_OP_ADD;
               rd_wr_req = 1'b1;
               imm       = XLEN'({instr_i[31:12], 12'b0});
            end
            default: illegal = 1'b1;
         endcase
      end

      if (illegal) begin
         alu_op    = ALU_OP_NONE;
         rd_wr_req = 1'b0;
         exc_req   = 1'b1;
         exc_code  = EXC_ILLEGAL;
      end
   end

   always_ff @(posedge clk or negedge arst_n_i) begin
      if (!arst_n_i) begin
         id2exe.valid <= 1'b0;
      end else begin
         id2exe.valid <= instr_valid_i;
      end
   end

   always_ff @(posedge clk) begin
      id2exe.pc        <= pc_i;
      id2exe.rs1_data  <= fwd_operand(rs1_addr_o, rs1_data_i);
      id2exe.rs2_data  <= fwd_operand(rs2_addr_o, rs2_data_i);
      id2exe.imm       <= imm;
      id2exe.rd_addr   <= instr_i[11:7];
      id2exe.alu_op    <= alu_op;
      id2exe.opr1_sel  <= opr1_sel;
      id2exe.opr2_sel  <= opr2_sel;
      id2exe.rd_wr_req <= rd_wr_req;
      id2exe.exc_req   <= exc_req;
      id2exe.exc_code  <= exc_code;
   end

endmodule : instr_decode

`default_nettype wire

//--- hw/alu_execute.sv
// Integer ALU with operand selection and the execute to result pipeline register
`default_nettype none

module alu_execute #(
   parameter int XLEN = rv_core_pkg::XLEN
) (
   input  wire logic              clk,
   input  wire logic              arst_n_i,
   id2exe_if.execute              id2exe,
   output rv_core_pkg::fwd_t      exe_fwd_o,
   output logic                   exe2wb_valid_o,
   output logic [XLEN-1:0]        exe2wb_pc_o,
   output rv_core_pkg::rf_addr_t  exe2wb_rd_addr_o,
   output logic [XLEN-1:0]        exe2wb_rd_data_o,
   output logic                   exe2wb_rd_wr_o,
   output logic                   exe2wb_exc_o,
   output rv_core_pkg::exc_code_t exe2wb_exc_code_o
);
   import rv_core_pkg::*;

   logic [XLEN-1:0] opr1;
   logic [XLEN-1:0] opr2;
   logic [4:0]      shamt;
   logic [XLEN-1:0] alu_result;

   assign opr1  = (id2exe.opr1_sel == OPR1_PC) ? id2exe.pc : id2exe.rs1_data;
   assign opr2  = (id2exe.opr2_sel == OPR2_IMM) ? id2exe.imm : id2exe.rs2_data;
   assign shamt = opr2[4:0];  // Low 5 bits only

   always_comb begin
      case (id2exe.alu_op)
         ALU_OP_ADD:       alu_result = opr1 + opr2;
         ALU_OP_SUB:       alu_result = opr1 - opr2;
         ALU_OP_SLL:       alu_result = opr1 << shamt;
         ALU_OP_SLT:       alu_result = XLEN'($signed(opr1) < $signed(opr2));
         ALU_OP_SLTU:      alu_result = XLEN'(opr1 < opr2);
         ALU_OP_XOR:       alu_result = opr1 ^ opr2;
         ALU_OP_SRL:       alu_result = opr1 >> shamt;
         ALU_OP_SRA:       alu_result = $signed(opr1) >>> shamt;
         ALU_OP_OR:        alu_result = opr1 | opr2;
         ALU_OP_AND:       alu_result = opr1 & opr2;
         ALU_OP_COPY_OPR2: alu_result = opr2;
         default:          alu_result = '0;  // Exception slots
      endcase
   end

   // Distance-1 forward straight from the ALU
   always_comb begin
      exe_fwd_o.valid   = id2exe.valid & id2exe.rd_wr_req;
      exe_fwd_o.rd_addr = id2exe.rd_addr;
      exe_fwd_o.rd_data = alu_result;
   end

   always_ff @(posedge clk or negedge arst_n_i) begin
      if (!arst_n_i) begin
         exe2wb_valid_o <= 1'b0;
      end else begin
         exe2wb_valid_o <= id2exe.valid;
      end
   end

   always_ff @(posedge clk) begin
      exe2wb_pc_o       <= id2exe.pc;
      exe2wb_rd_addr_o  <= id2exe.rd_addr;
      exe2wb_rd_data_o  <= alu_result;
      exe2wb_rd_wr_o    <= id2exe.rd_wr_req;
      exe2wb_exc_o      <= id2exe.exc_req;
      exe2wb_exc_code_o <= id2exe.exc_code;
   end

endmodule : alu_execute

`default_nettype wire

//--- hw/writeback_result.sv
// Register write request and retired-instruction report
`default_nettype none

module writeback_result #(
   parameter int XLEN = rv_core_pkg::XLEN
) (
   input  wire logic                   exe2wb_valid_i,
   input  wire logic [XLEN-1:0]        exe2wb_pc_i,
   input  wire rv_core_pkg::rf_addr_t  exe2wb_rd_addr_i,
   input  wire logic [XLEN-1:0]        exe2wb_rd_data_i,
   input  wire logic                   exe2wb_rd_wr_i,
   input  wire logic                   exe2wb_exc_i,
   input  wire rv_core_pkg::exc_code_t exe2wb_exc_code_i,
   output rv_core_pkg::fwd_t           wb_fwd_o,
   output logic                        result_valid_o,
   output logic [XLEN-1:0]             result_pc_o,
   output rv_core_pkg::rf_addr_t       result_rd_addr_o,
   output logic [XLEN-1:0]             result_data_o,
   output logic                        result_wr_o,
   output logic                        result_exc_o,
   output rv_core_pkg::exc_code_t      result_exc_code_o
);
   import rv_core_pkg::*;

   logic rd_write;

   // No write on exception or to x0
   assign rd_write = exe2wb_valid_i & exe2wb_rd_wr_i & ~exe2wb_exc_i &
                     (exe2wb_rd_addr_i != '0);

   always_comb begin
      wb_fwd_o.valid   = rd_write;  // Also the register file write enable
      wb_fwd_o.rd_addr = exe2wb_rd_addr_i;
      wb_fwd_o.rd_data = exe2wb_rd_data_i;
   end

   assign result_valid_o    = exe2wb_valid_i;
   assign result_pc_o       = exe2wb_pc_i;
   assign result_rd_addr_o  = exe2wb_rd_addr_i;
   assign result_data_o     = exe2wb_rd_data_i;
   assign result_wr_o       = rd_write;
   assign result_exc_o      = exe2wb_valid_i & exe2wb_exc_i;
   assign result_exc_code_o = exe2wb_exc_i ? exe2wb_exc_code_i : EXC_NONE;

endmodule : writeback_result

`default_nettype wire

//--- hw/rv_int_core.sv
// Top level of the RV32I integer pipeline, decode, execute,
// result stage and register file
`default_nettype none

module rv_int_core #(
   parameter int XLEN = rv_core_pkg::XLEN
) (
   input  wire logic                   clk,
   input  wire logic                   arst_n_i,
   input  wire logic                   instr_valid_i,
   input  wire rv_core_pkg::instr_t    instr_i,
   input  wire logic [XLEN-1:0]        pc_i,
   input  wire logic                   fetch_fault_i,
   output logic                        result_valid_o,
   output logic [XLEN-1:0]             result_pc_o,
   output rv_core_pkg::rf_addr_t       result_rd_addr_o,
   output logic [XLEN-1:0]             result_data_o,
   output logic                        result_wr_o,
   output logic                        result_exc_o,
   output rv_core_pkg::exc_code_t      result_exc_code_o
);
   import rv_core_pkg::*;

   rf_addr_t        rs1_addr;
   rf_addr_t        rs2_addr;
   logic [XLEN-1:0] rs1_data;
   logic [XLEN-1:0] rs2_data;
   fwd_t            exe_fwd;
   fwd_t            wb_fwd;
   logic            exe2wb_valid;
   logic [XLEN-1:0] exe2wb_pc;
   rf_addr_t        exe2wb_rd_addr;
   logic [XLEN-1:0] exe2wb_rd_data;
   logic            exe2wb_rd_wr;
   logic            exe2wb_exc;
   exc_code_t       exe2wb_exc_code;

   id2exe_if #(.XLEN(XLEN)) id2exe ();

   reg_file #(.XLEN(XLEN)) reg_file_inst (
      .clk        (clk),
      .arst_n_i   (arst_n_i),
      .rs1_addr_i (rs1_addr),
      .rs2_addr_i (rs2_addr),
      .rs1_data_o (rs1_data),
      .rs2_data_o (rs2_data),
      .wr_en_i    (wb_fwd.valid),
      .wr_addr_i  (wb_fwd.rd_addr),
      .wr_data_i  (wb_fwd.rd_data)
   );

   instr_decode #(.XLEN(XLEN)) instr_decode_inst (
      .clk           (clk),
      .arst_n_i      (arst_n_i),
      .instr_valid_i (instr_valid_i),
      .instr_i       (instr_i),
      .pc_i          (pc_i),
      .fetch_fault_i (fetch_fault_i),
      .rs1_addr_o    (rs1_addr),
      .rs2_addr_o    (rs2_addr),
      .rs1_data_i    (rs1_data),
      .rs2_data_i    (rs2_data),
      .exe_fwd_i     (exe_fwd),
      .wb_fwd_i      (wb_fwd),
      .id2exe        (id2exe.decode)
   );

   alu_execute #(.XLEN(XLEN)) alu_execute_inst (
      .clk               (clk),
      .arst_n_i          (arst_n_i),
      .id2exe            (id2exe.execute),
      .exe_fwd_o         (exe_fwd),
      .exe2wb_valid_o    (exe2wb_valid),
      .exe2wb_pc_o       (exe2wb_pc),
      .exe2wb_rd_addr_o  (exe2wb_rd_addr),
      .exe2wb_rd_data_o  (exe2wb_rd_data),
      .exe2wb_rd_wr_o    (exe2wb_rd_wr),
      .exe2wb_exc_o      (exe2wb_exc),
      .exe2wb_exc_code_o (exe2wb_exc_code)
   );

   writeback_result #(.XLEN(XLEN)) writeback_result_inst (
      .exe2wb_valid_i    (exe2wb_valid),
      .exe2wb_pc_i       (exe2wb_pc),
      .exe2wb_rd_addr_i  (exe2wb_rd_addr),
      .exe2wb_rd_data_i  (exe2wb_rd_data),
      .exe2wb_rd_wr_i    (exe2wb_rd_wr),
      .exe2wb_exc_i      (exe2wb_exc),
      .exe2wb_exc_code_i (exe2wb_exc_code),
      .wb_fwd_o          (wb_fwd),
      .result_valid_o    (result_valid_o),
      .result_pc_o       (result_pc_o),
      .result_rd_addr_o  (result_rd_addr_o),
      .result_data_o     (result_data_o),
      .result_wr_o       (result_wr_o),
      .result_exc_o      (result_exc_o),
      .result_exc_code_o (result_exc_code_o)
   );

endmodule : rv_int_core

`default_nettype wire

//--- tests/tb_rv_int_core.sv
// Testbench of the RV32I integer core with vector file reader,
// instruction driver, result checker and watchdog
`default_nettype none

module tb_rv_int_core;
   timeunit 1ns;
   timeprecision 100ps;

   localparam int    XLEN       = 32;
   localparam int    CLK_PERIOD = 10;
   localparam int    SEED       = 62388;
   localparam string VEC_FILE   = "tests/core_input_vectors.txt";

   logic            clk;
   logic            arst_n;
   logic            instr_valid;
   logic [31:0]     instr;
   logic [XLEN-1:0] pc;
   logic            fetch_fault;
   logic            result_valid;
   logic [XLEN-1:0] result_pc;
   logic [4:0]      result_rd_addr;
   logic [XLEN-1:0] result_data;
   logic            result_wr;
   logic            result_exc;
   logic [3:0]      result_exc_code;

   // One entry per vector line
   logic [31:0]     v_instr [$];
   logic [XLEN-1:0] v_pc [$];
   logic            v_fault [$];
   logic            v_wr [$];
   logic [4:0]      v_rd [$];
   logic [XLEN-1:0] v_data [$];
   logic            v_exc [$];
   logic [3:0]      v_code [$];
   int              v_test [$];    // Owning test index

   string test_name [$];
   int    test_gap [$];            // Max idle cycles between instructions
   int    test_first [$];
   int    test_last [$];

   int  pending [$];               // Vector indices still in the pipeline
   time issue_time [$];            // Drive time of each pending vector
   int  err_count;
   int  test_err_base;
   bit  load_done;

   initial clk = 1'b0;
   always #(CLK_PERIOD / 2) clk = ~clk;

   rv_int_core #(.XLEN(XLEN)) rv_int_core_inst (
      .clk               (clk),
      .arst_n_i          (arst_n),
      .instr_valid_i     (instr_valid),
      .instr_i           (instr),
      .pc_i              (pc),
      .fetch_fault_i     (fetch_fault),
      .result_valid_o    (result_valid),
      .result_pc_o       (result_pc),
      .result_rd_addr_o  (result_rd_addr),
      .result_data_o     (result_data),
      .result_wr_o       (result_wr),
      .result_exc_o      (result_exc),
      .result_exc_code_o (result_exc_code)
   );

   task automatic check_value(input string name, input logic [31:0] actual,
                              input logic [31:0] expected);
      if (actual !== expected) begin
         $display("FAILED at %0d ns: %s = 0x%08h, expected 0x%08h",
                  $time, name, actual, expected);
         err_count++;
      end
   endtask

   task automatic load_vectors();
      int          fd;
      int          code;
      int          ch;
      int          cur_test;
      int          gap;
      string       tok;
      string       name;
      logic [31:0] f_instr;
      logic [31:0] f_pc;
      logic [31:0] f_fault;
      logic [31:0] f_wr;
      logic [31:0] f_rd;
      logic [31:0] f_data;
      logic [31:0] f_exc;
      logic [31:0] f_code;
      cur_test = -1;
      fd = $fopen(VEC_FILE, "r");
      if (fd == 0) begin
         $display("ERROR: cannot open vector file %s", VEC_FILE);
      end else begin
         while ($fscanf(fd, "%s", tok) == 1) begin
            if (tok.substr(0, 0) == "#") begin
               ch = $fgetc(fd);  // Drop the rest of the comment
               while (ch != 10 && ch != -1) begin
                  ch = $fgetc(fd);
               end
            end else if (tok == "test") begin
               code = $fscanf(fd, "%s %d", name, gap);
               if (code != 2) begin
                  $display("ERROR: malformed test line in the vector file");
                  err_count++;
               end
               test_name.push_back(name);
               test_gap.push_back(gap);
               test_first.push_back(v_instr.size());
               test_last.push_back(v_instr.size() - 1);
               cur_test = test_name.size() - 1;
            end else begin
               code = $sscanf(tok, "%h", f_instr);
               if (code == 1) begin
                  code = $fscanf(fd, "%h %h %h %h %h %h %h", f_pc, f_fault, f_wr,
                                 f_rd, f_data, f_exc, f_code);
               end
               if (code != 7 || cur_test < 0) begin
                  $display("ERROR: malformed vector line starting with %s", tok);
                  err_count++;
               end else begin
                  v_instr.push_back(f_instr);
                  v_pc.push_back(f_pc);
                  v_fault.push_back(f_fault[0]);
                  v_wr.push_back(f_wr[0]);
                  v_rd.push_back(f_rd[4:0]);
                  v_data.push_back(f_data);
                  v_exc.push_back(f_exc[0]);
                  v_code.push_back(f_code[3:0]);
                  v_test.push_back(cur_test);
                  test_last[cur_test] = v_instr.size() - 1;
               end
            end
         end
         $fclose(fd);
      end
   endtask

   task automatic run_vectors();
      int gap;
      for (int i = 0; i < v_instr.size(); i++) begin
         gap = 0;
         if (test_gap[v_test[i]] > 0) begin
            gap = $urandom_range(test_gap[v_test[i]], 0);
         end
         repeat (gap) begin
            @(negedge clk);
            instr_valid = 1'b0;
            fetch_fault = 1'b0;
         end
         @(negedge clk);
         instr_valid = 1'b1;
         instr       = v_instr[i];
         pc          = v_pc[i];
         fetch_fault = v_fault[i];
         pending.push_back(i);
         issue_time.push_back($time);
      end
      @(negedge clk);
      instr_valid = 1'b0;
      fetch_fault = 1'b0;
      repeat (4) @(negedge clk);  // Longer than the two-cycle latency
   endtask

   task automatic check_retired(input int idx, input time issued);
      int t;
      t = v_test[idx];
      if (idx == test_first[t]) begin
         test_err_base = err_count;
      end
      check_value("result_valid_o latency in cycles",
                  32'(($time - issued) / CLK_PERIOD), 32'd2);
      check_value("result_pc_o", result_pc, v_pc[idx]);
      check_value("result_rd_addr_o", 32'(result_rd_addr), 32'(v_rd[idx]));
      check_value("result_wr_o", 32'(result_wr), 32'(v_wr[idx]));
      check_value("result_exc_o", 32'(result_exc), 32'(v_exc[idx]));
      check_value("result_exc_code_o", 32'(result_exc_code), 32'(v_code[idx]));
      if (!v_exc[idx]) begin
         check_value("result_data_o", result_data, v_data[idx]);  // Data undefined on exception
      end
      if (idx == test_last[t]) begin
         if (err_count == test_err_base) begin
            $display("Test %s passed, %0d instructions", test_name[t],
                     test_last[t] - test_first[t] + 1);
         end else begin
            $display("Test %s failed with %0d errors", test_name[t],
                     err_count - test_err_base);
         end
      end
   endtask

   // Outputs are registered, so mid-cycle sampling is stable
   always @(negedge clk) begin
      if (!arst_n) begin
         check_value("result_valid_o", 32'(result_valid), 32'd0);
      end else if (result_valid) begin
         if (pending.size() == 0) begin
            $display("ERROR at %0d ns: a result retired with no instruction outstanding",
                     $time);
            err_count++;
         end else begin
            check_retired(pending.pop_front(), issue_time.pop_front());
         end
      end
   end

   initial begin
      instr_valid   = 1'b0;
      instr         = '0;
      pc            = '0;
      fetch_fault   = 1'b0;
      arst_n        = 1'b0;
      err_count     = 0;
      test_err_base = 0;
      void'($urandom(SEED));
      load_vectors();
      load_done = 1'b1;
      repeat (4) @(posedge clk);
      @(negedge clk);
      arst_n = 1'b1;
      repeat (3) @(negedge clk);  // Idle after reset, nothing may retire
      if (v_instr.size() == 0) begin
         $display("ERROR: no vectors were loaded");
         err_count++;
      end else begin
         run_vectors();
      end
      if (pending.size() != 0) begin
         $display("ERROR: %0d instructions never retired", pending.size());
         err_count++;
      end
      $display("Tests: %0d, instructions: %0d, errors: %0d",
               test_name.size(), v_instr.size(), err_count);
      if (err_count == 0) begin
         $display("SIMULATION PASSED");
      end else begin
         $display("SIMULATION FAILED");
      end
      $finish;
   end

   initial begin
      int unsigned limit;
      wait (load_done);
      limit = v_instr.size() * 4 + 100;
      repeat (limit) @(posedge clk);
      $display("ERROR: watchdog expired after %0d cycles with %0d results outstanding",
               limit, pending.size());
      $display("SIMULATION FAILED");
      $finish;
   end

endmodule : tb_rv_int_core

`default_nettype wire

//--- tests/core_input_vectors.txt
# Test lines: test <name> <max idle cycles between instructions>
# Vector lines (hex): instr pc fetch_fault exp_wr exp_rd exp_data exp_exc exp_code
test reset_reads 2
004182B3 00000000 0 1 05 00000000 0 0  # add   x5, x3, x4
01F00333 00000004 0 1 06 00000000 0 0  # add   x6, x0, x31
test rtype 2
800000B7 00000100 0 1 01 80000000 0 0  # lui   x1, 0x80000
0F008093 00000104 0 1 01 800000F0 0 0  # addi  x1, x1, 0xf0
00500113 00000108 0 1 02 00000005 0 0  # addi  x2, x0, 5
002081B3 0000010C 0 1 03 800000F5 0 0  # add   x3, x1, x2
40208233 00000110 0 1 04 800000EB 0 0  # sub   x4, x1, x2
002092B3 00000114 0 1 05 00001E00 0 0  # sll   x5, x1, x2
0020A333 00000118 0 1 06 00000001 0 0  # slt   x6, x1, x2
0020B3B3 0000011C 0 1 07 00000000 0 0  # sltu  x7, x1, x2
0020C433 00000120 0 1 08 800000F5 0 0  # xor   x8, x1, x2
0020D4B3 00000124 0 1 09 04000007 0 0  # srl   x9, x1, x2
4020D533 00000128 0 1 0A FC000007 0 0  # sra   x10, x1, x2
0020E5B3 0000012C 0 1 0B 800000F5 0 0  # or    x11, x1, x2
0020F633 00000130 0 1 0C 00000000 0 0  # and   x12, x1, x2
test itype 2
FFF0A693 00000200 0 1 0D 00000001 0 0  # slti  x13, x1, -1
FFF13713 00000204 0 1 0E 00000001 0 0  # sltiu x14, x2, -1
FFF14793 00000208 0 1 0F FFFFFFFA 0 0  # xori  x15, x2, -1
00F0E813 0000020C 0 1 10 800000FF 0 0  # ori   x16, x1, 0xf
0FF0F893 00000210 0 1 11 000000F0 0 0  # andi  x17, x1, 0xff
01F11913 00000214 0 1 12 80000000 0 0  # slli  x18, x2, 31
0040D993 00000218 0 1 13 0800000F 0 0  # srli  x19, x1, 4
4040DA13 0000021C 0 1 14 F800000F 0 0  # srai  x20, x1, 4
FFA10B93 00000220 0 1 17 FFFFFFFF 0 0  # addi  x23, x2, -6
12345AB7 00000224 0 1 15 12345000 0 0  # lui   x21, 0x12345
FFFFFB17 00000228 0 1 16 FFFFF228 0 0  # auipc x22, 0xfffff
test forwarding 0
12300C13 00000300 0 1 18 00000123 0 0  # addi  x24, x0, 0x123
001C0C93 00000304 0 1 19 00000124 0 0  # addi  x25, x24, 1
019C0D33 00000308 0 1 1A 00000247 0 0  # add   x26, x24, x25
418D0DB3 0000030C 0 1 1B 00000124 0 0  # sub   x27, x26, x24
001C0C13 00000310 0 1 18 00000124 0 0  # addi  x24, x24, 1
001C0C13 00000314 0 1 18 00000125 0 0  # addi  x24, x24, 1
018C0E33 00000318 0 1 1C 0000024A 0 0  # add   x28, x24, x24
test exceptions 2
038C0EB3 00000400 0 0 1D 00000000 1 2  # mul   x29, x24, x24
00002C03 00000404 0 0 18 00000000 1 2  # lw    x24, 0(x0)
401C1C13 00000408 0 0 18 00000000 1 2  # slli  x24, x24, 1 with funct7 0x20
00700C13 0000040C 1 0 18 00000000 1 1  # addi  x24, x0, 7 under fetch fault
05500013 00000410 0 0 00 00000055 0 0  # addi  x0, x0, 0x55
000C0F33 00000414 0 1 1E 00000125 0 0  # add   x30, x24, x0
000E8FB3 00000418 0 1 1F 00000000 0 0  # add   x31, x29, x0

//--- list.f
hw/rv_core_pkg.sv
hw/id2exe_if.sv
hw/reg_file.sv
hw/instr_decode.sv
hw/alu_execute.sv
hw/writeback_result.sv
hw/rv_int_core.sv
tests/tb_rv_int_core.sv

//--- run_sim.sh
#!/usr/bin/env bash
# Compile and run the RV32I core testbench with Verilator
set -u

cd "$(dirname "$0")" || exit 1

LOG=sim.log
OBJ_DIR=obj_dir
TOP=tb_rv_int_core

verilator --binary --timing --timescale 1ns/100ps \
   --top-module "$TOP" -Mdir "$OBJ_DIR" -o "$TOP" -f list.f
if [ $? -ne 0 ]; then
   echo "Verilator build failed"
   exit 1
fi

"./$OBJ_DIR/$TOP" > "$LOG" 2>&1
run_status=$?
cat "$LOG"
if [ $run_status -ne 0 ]; then
   echo "Simulation exited with status $run_status"
   exit 1
fi

if grep -q "SIMULATION FAILED" "$LOG"; then
   exit 1
fi
exit 0
